// File: logic/noc_rx_macros.svh
`ifndef NOC_RX_MACROS_SVH
`define NOC_RX_MACROS_SVH

// Width of one NoC flit
`define NOC_DATA_WIDTH 64

// Message length counts every flit after the header, metadata and payload alike
`define MSG_LENGTH_WIDTH 8

`define MSG_META_FLITS_WIDTH 4

// Input FIFO depth must be a power of two
`define RX_FIFO_DEPTH 4

`endif

// File: logic/noc_rx_pkg.sv
`include "noc_rx_macros.svh"

package noc_rx_pkg;

    typedef enum logic [7:0] {
        MSG_DATA = 8'd0,
        MSG_CTRL = 8'd1,
        MSG_ACK  = 8'd2,
        MSG_CFG  = 8'd3
    } msg_type_e;

    // Header flit layout with the most significant field first
    typedef struct packed {
        logic [7:0]                       dst_x;
        logic [7:0]                       dst_y;
        msg_type_e                        msg_type;
        logic [`MSG_LENGTH_WIDTH-1:0]     msg_len;
        logic [`MSG_META_FLITS_WIDTH-1:0] metadata_flits;
        logic [`NOC_DATA_WIDTH-24-`MSG_LENGTH_WIDTH-`MSG_META_FLITS_WIDTH-1:0] reserved;
    } noc_hdr_flit_t;

    typedef enum logic [1:0] {
        HDR_FLIT   = 2'd0,
        META_FLITS = 2'd1,
        DATA_FLITS = 2'd2
    } strip_state_e;

endpackage

// File: logic/flit_stream_if.sv
`timescale 1ns/1ps
`include "noc_rx_macros.svh"

// One valid/ready flit stream where last marks the end of a group of flits
interface flit_stream_if;
    logic                       val;
    logic [`NOC_DATA_WIDTH-1:0] data;
    logic                       last;
    logic                       rdy;

    modport source (
        output val,
        output data,
        output last,
        input  rdy
    );

    modport sink (
        input  val,
        input  data,
        input  last,
        output rdy
    );
endinterface

// File: logic/flit_in_fifo.sv
`timescale 1ns/1ps
`include "noc_rx_macros.svh"

module flit_in_fifo (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       in_val,
    input  logic [`NOC_DATA_WIDTH-1:0] in_data,
    output logic                       in_rdy,

    flit_stream_if.source              out
);
    localparam int PTR_W = $clog2(`RX_FIFO_DEPTH);

    logic [`NOC_DATA_WIDTH-1:0] mem [`RX_FIFO_DEPTH];
    logic [PTR_W-1:0]           wr_ptr;
    logic [PTR_W-1:0]           rd_ptr;
    logic [PTR_W:0]             count;
    logic                       wr_en;
    logic                       rd_en;
    logic                       full;
    logic                       empty;

    assign full  = count == (PTR_W+1)'(`RX_FIFO_DEPTH);
    assign empty = count == '0;

    assign in_rdy = !full;
    assign wr_en  = in_val && !full;
    assign rd_en  = out.val && out.rdy;

    // Head is visible the cycle after it is written
    assign out.val  = !empty;
    assign out.data = mem[rd_ptr];
    assign out.last = 1'b0;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end
endmodule

// File: logic/flit_hdr_strip.sv
`timescale 1ns/1ps
`include "noc_rx_macros.svh"

module flit_hdr_strip
    import noc_rx_pkg::*;
(
    input  logic         clk,
    input  logic         rst,

    flit_stream_if.sink   src,
    flit_stream_if.source hdr,
    flit_stream_if.source dat
);
    strip_state_e state_reg;
    strip_state_e state_next;

    logic [`MSG_LENGTH_WIDTH-1:0]     msg_flit_cnt_reg;
    logic [`MSG_LENGTH_WIDTH-1:0]     msg_flit_cnt_next;
    logic [`MSG_META_FLITS_WIDTH-1:0] meta_flit_cnt_reg;
    logic [`MSG_META_FLITS_WIDTH-1:0] meta_flit_cnt_next;
    logic                             load_cnt;
    logic                             decr_msg_cnt;
    logic                             decr_meta_cnt;

    noc_hdr_flit_t hdr_flit;

    assign hdr_flit = src.data;

    // Both paths see the same flit and only the valids are steered
    assign hdr.data = src.data;
    assign dat.data = src.data;
    assign dat.last = msg_flit_cnt_reg == `MSG_LENGTH_WIDTH'(1);

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg         <= HDR_FLIT;
            msg_flit_cnt_reg  <= '0;
            meta_flit_cnt_reg <= '0;
        end else begin
            state_reg         <= state_next;
            msg_flit_cnt_reg  <= msg_flit_cnt_next;
            meta_flit_cnt_reg <= meta_flit_cnt_next;
        end
    end

    always_comb begin
        msg_flit_cnt_next = msg_flit_cnt_reg;
        if (load_cnt) begin
            msg_flit_cnt_next = hdr_flit.msg_len;
        end else if (decr_msg_cnt) begin
            msg_flit_cnt_next = msg_flit_cnt_reg - 1'b1;
        end
    end

    always_comb begin
        meta_flit_cnt_next = meta_flit_cnt_reg;
        if (load_cnt) begin
            meta_flit_cnt_next = hdr_flit.metadata_flits;
        end else if (decr_meta_cnt) begin
            meta_flit_cnt_next = meta_flit_cnt_reg - 1'b1;
        end
    end

    always_comb begin
        hdr.val       = 1'b0;
        hdr.last      = 1'b0;
        dat.val       = 1'b0;
        src.rdy       = 1'b0;
        load_cnt      = 1'b0;
        decr_msg_cnt  = 1'b0;
        decr_meta_cnt = 1'b0;
        state_next    = state_reg;

        case (state_reg)
            HDR_FLIT: begin
                hdr.val = src.val;
                src.rdy = hdr.rdy;
                if (src.val && hdr.rdy) begin
                    load_cnt = 1'b1;
                    if (hdr_flit.msg_len == '0) begin
                        // Header-only message ends here
                        hdr.last = 1'b1;
                    end else if (hdr_flit.metadata_flits == '0) begin
                        hdr.last   = 1'b1;
                        state_next = DATA_FLITS;
                    end else begin
                        state_next = META_FLITS;
                    end
                end
            end
            META_FLITS: begin
                hdr.val = src.val;
                src.rdy = hdr.rdy;
                if (src.val && hdr.rdy) begin
                    decr_msg_cnt  = 1'b1;
                    decr_meta_cnt = 1'b1;
                    if (msg_flit_cnt_reg == `MSG_LENGTH_WIDTH'(1)) begin
                        // Metadata fills the whole message so no payload follows
                        hdr.last   = 1'b1;
                        state_next = HDR_FLIT;
                    end else if (meta_flit_cnt_reg == `MSG_META_FLITS_WIDTH'(1)) begin
                        hdr.last   = 1'b1;
                        state_next = DATA_FLITS;
                    end
                end
            end
            DATA_FLITS: begin
                dat.val = src.val;
                src.rdy = dat.rdy;
                if (src.val && dat.rdy) begin
                    decr_msg_cnt = 1'b1;
                    if (msg_flit_cnt_reg == `MSG_LENGTH_WIDTH'(1)) begin
                        state_next = HDR_FLIT;
                    end
                end
            end
            default: begin
                state_next = HDR_FLIT;
            end
        endcase
    end
endmodule

// File: logic/msg_hdr_parse.sv
`timescale 1ns/1ps
`include "noc_rx_macros.svh"

module msg_hdr_parse
    import noc_rx_pkg::*;
(
    input  logic                             clk,
    input  logic                             rst,

    flit_stream_if.sink                      hdr,

    output logic                             desc_val,
    output msg_type_e                        desc_type,
    output logic [`MSG_LENGTH_WIDTH-1:0]     desc_len,
    output logic [`MSG_META_FLITS_WIDTH-1:0] desc_meta_flits,
    output logic [`NOC_DATA_WIDTH-1:0]       desc_meta,
    input  logic                             desc_rdy
);
    noc_hdr_flit_t hdr_flit;
    logic          hdr_xfer;
    logic          at_hdr;
    logic          got_meta;

    assign hdr_flit = hdr.data;

    // A finished descriptor blocks the next header until it is taken
    assign hdr.rdy  = !desc_val;
    assign hdr_xfer = hdr.val && hdr.rdy;

    always_ff @(posedge clk) begin
        if (rst) begin
            desc_val <= 1'b0;
            at_hdr   <= 1'b1;
            got_meta <= 1'b0;
        end else begin
            if (desc_val && desc_rdy) begin
                desc_val <= 1'b0;
            end
            if (hdr_xfer) begin
                if (hdr.last) begin
                    desc_val <= 1'b1;
                    at_hdr   <= 1'b1;
                end else begin
                    at_hdr <= 1'b0;
                end
                if (at_hdr) begin
                    got_meta <= 1'b0;
                end else begin
                    got_meta <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_xfer) begin
            if (at_hdr) begin
                desc_type       <= hdr_flit.msg_type;
                desc_len        <= hdr_flit.msg_len;
                desc_meta_flits <= hdr_flit.metadata_flits;
                desc_meta       <= '0;
            end else if (!got_meta) begin
                // Only the first metadata flit is kept
                desc_meta <= hdr.data;
            end
        end
    end
endmodule

// File: logic/noc_msg_rx.sv
`timescale 1ns/1ps
`include "noc_rx_macros.svh"

module noc_msg_rx
    import noc_rx_pkg::*;
(
    input  logic                             clk,
    input  logic                             rst,

    input  logic                             in_val,
    input  logic [`NOC_DATA_WIDTH-1:0]       in_data,
    output logic                             in_rdy,

    output logic                             desc_val,
    output msg_type_e                        desc_type,
    output logic [`MSG_LENGTH_WIDTH-1:0]     desc_len,
    output logic [`MSG_META_FLITS_WIDTH-1:0] desc_meta_flits,
    output logic [`NOC_DATA_WIDTH-1:0]       desc_meta,
    input  logic                             desc_rdy,

    output logic                             data_val,
    output logic [`NOC_DATA_WIDTH-1:0]       data,
    output logic                             data_last,
    input  logic                             data_rdy
);
    flit_stream_if fifo_out ();
    flit_stream_if hdr_path ();
    flit_stream_if data_path ();

    flit_in_fifo u_fifo (
        .clk     (clk),
        .rst     (rst),
        .in_val  (in_val),
        .in_data (in_data),
        .in_rdy  (in_rdy),
        .out     (fifo_out.source)
    );

    flit_hdr_strip u_strip (
        .clk (clk),
        .rst (rst),
        .src (fifo_out.sink),
        .hdr (hdr_path.source),
        .dat (data_path.source)
    );

    msg_hdr_parse u_parse (
        .clk             (clk),
        .rst             (rst),
        .hdr             (hdr_path.sink),
        .desc_val        (desc_val),
        .desc_type       (desc_type),
        .desc_len        (desc_len),
        .desc_meta_flits (desc_meta_flits),
        .desc_meta       (desc_meta),
        .desc_rdy        (desc_rdy)
    );

    // Payload path goes straight out to the data ports
    assign data_val      = data_path.val;
    assign data          = data_path.data;
    assign data_last     = data_path.last;
    assign data_path.rdy = data_rdy;
endmodule

// File: bench/noc_msg_rx_props.sv
`timescale 1ns/1ps
`include "noc_rx_macros.svh"

module noc_msg_rx_props
    import noc_rx_pkg::*;
(
    input logic                             clk,
    input logic                             rst,
    input logic                             data_val,
    input logic [`NOC_DATA_WIDTH-1:0]       data,
    input logic                             data_last,
    input logic                             data_rdy,
    input logic                             desc_val,
    input msg_type_e                        desc_type,
    input logic [`MSG_LENGTH_WIDTH-1:0]     desc_len,
    input logic [`MSG_META_FLITS_WIDTH-1:0] desc_meta_flits,
    input logic [`NOC_DATA_WIDTH-1:0]       desc_meta,
    input logic                             desc_rdy,
    input strip_state_e                     strip_state
);
    data_hold: assert property (@(posedge clk) disable iff (rst)
        data_val && !data_rdy |=> data_val && $stable(data) && $stable(data_last))
        else $error("Payload flit changed or dropped while data_rdy was low");

    desc_hold: assert property (@(posedge clk) disable iff (rst)
        desc_val && !desc_rdy |=> desc_val && $stable(desc_type) && $stable(desc_len)
            && $stable(desc_meta_flits) && $stable(desc_meta))
        else $error("Descriptor changed or dropped before desc_rdy");

    // The payload phase may only end with the final payload transfer
    strip_exit: assert property (@(posedge clk) disable iff (rst)
        strip_state == DATA_FLITS && !(data_val && data_rdy && data_last)
            |=> strip_state == DATA_FLITS)
        else $error("Stripper left DATA_FLITS without a final payload transfer");
endmodule

bind noc_msg_rx noc_msg_rx_props u_props (
    .clk             (clk),
    .rst             (rst),
    .data_val        (data_val),
    .data            (data),
    .data_last       (data_last),
    .data_rdy        (data_rdy),
    .desc_val        (desc_val),
    .desc_type       (desc_type),
    .desc_len        (desc_len),
    .desc_meta_flits (desc_meta_flits),
    .desc_meta       (desc_meta),
    .desc_rdy        (desc_rdy),
    .strip_state     (u_strip.state_reg)
);

// File: bench/noc_msg_rx_tb.sv
`timescale 1ns/1ps
`include "noc_rx_macros.svh"

module noc_msg_rx_tb
    import noc_rx_pkg::*;
();
    localparam int NUM_ROWS   = 8;
    localparam int CLK_HALF   = 50;
    localparam int RST_CYCLES = 16;

    logic                             clk;
    logic                             rst;
    logic                             in_val;
    logic [`NOC_DATA_WIDTH-1:0]       in_data;
    logic                             in_rdy;
    logic                             desc_val;
    msg_type_e                        desc_type;
    logic [`MSG_LENGTH_WIDTH-1:0]     desc_len;
    logic [`MSG_META_FLITS_WIDTH-1:0] desc_meta_flits;
    logic [`NOC_DATA_WIDTH-1:0]       desc_meta;
    logic                             desc_rdy;
    logic                             data_val;
    logic [`NOC_DATA_WIDTH-1:0]       data;
    logic                             data_last;
    logic                             data_rdy;

    // Stimulus table with one message per row
    string                            row_name [NUM_ROWS];
    msg_type_e                        row_type [NUM_ROWS];
    logic [`MSG_LENGTH_WIDTH-1:0]     row_len  [NUM_ROWS];
    logic [`MSG_META_FLITS_WIDTH-1:0] row_meta [NUM_ROWS];
    logic [`NOC_DATA_WIDTH-1:0]       row_base [NUM_ROWS];
    logic                             row_bp   [NUM_ROWS];

    int                         row_err   [NUM_ROWS];
    bit                         desc_done [NUM_ROWS];
    bit                         data_done [NUM_ROWS];
    int                         desc_idx;
    int                         data_idx;
    int                         data_k;
    int                         err_count;
    int                         tests_done;
    int                         tests_failed;
    bit                         table_ready;
    bit                         data_hold;
    bit                         desc_hold;
    logic [`NOC_DATA_WIDTH:0]   held_data;
    logic [`NOC_DATA_WIDTH+19:0] held_desc;

    noc_msg_rx DUT (
        .clk             (clk),
        .rst             (rst),
        .in_val          (in_val),
        .in_data         (in_data),
        .in_rdy          (in_rdy),
        .desc_val        (desc_val),
        .desc_type       (desc_type),
        .desc_len        (desc_len),
        .desc_meta_flits (desc_meta_flits),
        .desc_meta       (desc_meta),
        .desc_rdy        (desc_rdy),
        .data_val        (data_val),
        .data            (data),
        .data_last       (data_last),
        .data_rdy        (data_rdy)
    );

    always #CLK_HALF clk = ~clk;

    task automatic set_row(input int i, input string name, input msg_type_e t, input int len,
                           input int meta, input logic [63:0] base, input bit bp);
        row_name[i] = name;
        row_type[i] = t;
        row_len[i]  = len[`MSG_LENGTH_WIDTH-1:0];
        row_meta[i] = meta[`MSG_META_FLITS_WIDTH-1:0];
        row_base[i] = base;
        row_bp[i]   = bp;
    endtask

    function automatic int payload_count(input int i);
        return (row_len[i] > row_meta[i]) ? int'(row_len[i]) - int'(row_meta[i]) : 0;
    endfunction

    function automatic logic [`NOC_DATA_WIDTH-1:0] make_header(input int i);
        noc_hdr_flit_t h;
        h                = '0;
        h.dst_x          = 8'(i + 1);
        h.dst_y          = 8'(2 * i);
        h.msg_type       = row_type[i];
        h.msg_len        = row_len[i];
        h.metadata_flits = row_meta[i];
        return h;
    endfunction

    task automatic compare_field(input int i, input string what,
                                 input logic [63:0] exp, input logic [63:0] act);
        if (act !== exp) begin
            $display("FAIL %s %s: expected %0h, actual %0h", row_name[i], what, exp, act);
            row_err[i]++;
            err_count++;
        end
    endtask

    task automatic finish_test(input int i);
        if (desc_done[i] && data_done[i]) begin
            if (row_err[i] == 0) begin
                $display("test %s passed", row_name[i]);
            end else begin
                $display("test %s failed with %0d errors", row_name[i], row_err[i]);
                tests_failed++;
            end
            tests_done++;
        end
    endtask

    task automatic skip_empty_rows();
        while (data_idx < NUM_ROWS && payload_count(data_idx) == 0) begin
            data_idx++;
        end
    endtask

    task automatic check_desc();
        logic [63:0] exp_meta;
        if (desc_idx >= NUM_ROWS) begin
            $display("Descriptor arrived after every message was complete");
            err_count++;
        end else begin
            exp_meta = (row_meta[desc_idx] != 0) ? row_base[desc_idx] + 100 : '0;
            compare_field(desc_idx, "desc_type", 64'(row_type[desc_idx]), 64'(desc_type));
            compare_field(desc_idx, "desc_len", 64'(row_len[desc_idx]), 64'(desc_len));
            compare_field(desc_idx, "desc_meta_flits", 64'(row_meta[desc_idx]),
                          64'(desc_meta_flits));
            compare_field(desc_idx, "desc_meta", exp_meta, desc_meta);
            desc_done[desc_idx] = 1'b1;
            finish_test(desc_idx);
            desc_idx++;
        end
    endtask

    task automatic check_data();
        int cnt;
        if (data_idx >= NUM_ROWS) begin
            $display("Payload flit %0h arrived after every message was complete", data);
            err_count++;
        end else begin
            cnt = payload_count(data_idx);
            compare_field(data_idx, $sformatf("payload[%0d]", data_k),
                          row_base[data_idx] + data_k, data);
            compare_field(data_idx, "data_last", 64'(data_k == cnt - 1), 64'(data_last));
            data_k++;
            if (data_k == cnt) begin
                data_done[data_idx] = 1'b1;
                finish_test(data_idx);
                data_idx++;
                data_k = 0;
                skip_empty_rows();
            end
        end
    endtask

    // Outputs are sampled mid-cycle and a transfer completes at the next rising edge
    always @(negedge clk) begin
        if (!rst && table_ready) begin
            if (data_hold && (!data_val || {data_last, data} !== held_data)) begin
                $display("Payload output changed while it waited for data_rdy");
                err_count++;
            end
            if (desc_hold && (!desc_val ||
                {desc_type, desc_len, desc_meta_flits, desc_meta} !== held_desc)) begin
                $display("Descriptor changed while it waited for desc_rdy");
                err_count++;
            end
            if (desc_val && desc_rdy) begin
                check_desc();
            end
            if (data_val && data_rdy) begin
                check_data();
            end
            data_hold = data_val && !data_rdy;
            held_data = {data_last, data};
            desc_hold = desc_val && !desc_rdy;
            held_desc = {desc_type, desc_len, desc_meta_flits, desc_meta};
        end
    end

    task automatic send_flit(input logic [`NOC_DATA_WIDTH-1:0] flit);
        bit taken;
        taken = 1'b0;
        in_val  <= 1'b1;
        in_data <= flit;
        while (!taken) begin
            @(negedge clk);
            taken = in_rdy;
            @(posedge clk);
        end
    endtask

    // Random ready only while the row expected on that output asks for back-pressure
    initial begin
        void'($urandom(32'h21c4));
        forever begin
            @(posedge clk);
            if (rst || desc_idx >= NUM_ROWS || !row_bp[desc_idx]) begin
                desc_rdy <= 1'b1;
            end else begin
                desc_rdy <= 1'($urandom_range(0, 1));
            end
            if (rst || data_idx >= NUM_ROWS || !row_bp[data_idx]) begin
                data_rdy <= 1'b1;
            end else begin
                data_rdy <= 1'($urandom_range(0, 1));
            end
        end
    end

    initial begin
        int total_flits;
        int limit;
        wait (table_ready);
        total_flits = 0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            total_flits += 1 + int'(row_len[i]);
        end
        limit = total_flits * 20 + RST_CYCLES;
        repeat (limit) @(posedge clk);
        $display("Run timed out after %0d cycles before every message was received", limit);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        int rst_err;
        clk      = 1'b0;
        rst      = 1'b1;
        in_val   = 1'b0;
        in_data  = '0;
        desc_rdy = 1'b1;
        data_rdy = 1'b1;
        desc_idx = 0;
        data_idx = 0;
        data_k   = 0;
        err_count    = 0;
        tests_done   = 0;
        tests_failed = 0;
        set_row(0, "meta_and_payload", MSG_DATA, 5, 2, 64'h1000, 1'b0);
        set_row(1, "payload_no_meta",  MSG_CTRL, 3, 0, 64'h2000, 1'b0);
        set_row(2, "header_only",      MSG_ACK,  0, 0, 64'h3000, 1'b0);
        set_row(3, "meta_only",        MSG_CFG,  2, 2, 64'h4000, 1'b0);
        set_row(4, "bp_long",          MSG_DATA, 9, 1, 64'h5000, 1'b1);
        set_row(5, "bp_short",         MSG_CTRL, 1, 0, 64'h6000, 1'b1);
        set_row(6, "bp_meta_only",     MSG_CFG,  3, 3, 64'h7000, 1'b1);
        set_row(7, "bp_mixed",         MSG_ACK,  6, 3, 64'h8000, 1'b1);
        for (int i = 0; i < NUM_ROWS; i++) begin
            row_err[i]   = 0;
            desc_done[i] = 1'b0;
            data_done[i] = payload_count(i) == 0;
        end
        skip_empty_rows();
        table_ready = 1'b1;

        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        rst_err = err_count;
        if (in_rdy !== 1'b1) begin
            $display("FAIL reset_state in_rdy: expected 1, actual %b", in_rdy);
            err_count++;
        end
        if (desc_val !== 1'b0) begin
            $display("FAIL reset_state desc_val: expected 0, actual %b", desc_val);
            err_count++;
        end
        if (data_val !== 1'b0) begin
            $display("FAIL reset_state data_val: expected 0, actual %b", data_val);
            err_count++;
        end
        if (err_count == rst_err) begin
            $display("test reset_state passed");
        end else begin
            $display("test reset_state failed with %0d errors", err_count - rst_err);
            tests_failed++;
        end

        @(posedge clk);
        for (int i = 0; i < NUM_ROWS; i++) begin
            send_flit(make_header(i));
            for (int k = 0; k < int'(row_meta[i]); k++) begin
                send_flit(row_base[i] + 100 + k);
            end
            for (int k = 0; k < payload_count(i); k++) begin
                send_flit(row_base[i] + k);
            end
        end
        in_val <= 1'b0;

        wait (tests_done == NUM_ROWS);
        // A few idle cycles catch any stray transfer after the last message
        repeat (10) @(posedge clk);
        $display("Tests run %0d, failed %0d, errors %0d", NUM_ROWS + 1, tests_failed, err_count);
        if (err_count == 0 && tests_failed == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end
endmodule

// File: compile.f
+incdir+logic
logic/noc_rx_pkg.sv
logic/flit_stream_if.sv
logic/flit_in_fifo.sv
logic/flit_hdr_strip.sv
logic/msg_hdr_parse.sv
logic/noc_msg_rx.sv
bench/noc_msg_rx_props.sv
bench/noc_msg_rx_tb.sv
